// ==== dv/xm_regs_cases.txt ====
# op reg sel data expect, all hex; W expects intr_clear_o, M checks vram word at data
# D sets ack delay to data (ffff for random), TIMER waits data ticks between two reads
R 0 0 0000 0008
R 0 1 0000 000f
R 7 1 0000 0000
W 6 1 0002 0000
W 8 1 0003 0000
W 9 1 0010 0000
R 8 1 0000 0003
W 1 0 0055 0000
R 1 0 0000 0055
R 1 1 0000 0012
W 1 1 002c 002c
W a 0 0012 0000
W a 1 0034 0000
WAITIDLE 0 0 0000 0000
W b 0 0056 0000
W b 1 0078 0000
WAITIDLE 0 0 0000 0000
W 0 1 0005 0000
D 0 0 0014 0000
W a 1 0001 0000
R 0 0 0000 0088
WAITIDLE 0 0 0000 0000
R 0 0 0000 0008
D 0 0 ffff 0000
M 0 0 0010 1234
M 0 0 0013 5678
M 0 0 0016 e611
R 9 1 0000 0019
W 7 1 0010 0000
WAITIDLE 0 0 0000 0000
R a 0 0000 0012
R a 1 0000 0034
WAITIDLE 0 0 0000 0000
R b 0 0000 00ed
R b 1 0000 0012
TIMER 2 0 000a 000a

// ==== xm_regs.f ====
hdl/xm_pkg.sv
hdl/vram_req_if.sv
hdl/tenth_ms_timer.sv
hdl/vram_access_fsm.sv
hdl/xm_reg_file.sv
hdl/xm_regs_top.sv
dv/xm_regs_sva.sv
dv/tb_xm_regs.sv

// ==== Bender.yml ====
package:
  name: xm_regs

sources:
  - hdl/xm_pkg.sv
  - hdl/vram_req_if.sv
  - hdl/tenth_ms_timer.sv
  - hdl/vram_access_fsm.sv
  - hdl/xm_reg_file.sv
  - hdl/xm_regs_top.sv
  - target: simulation
    files:
      - dv/xm_regs_sva.sv
      - dv/tb_xm_regs.sv

// ==== dv/tb_xm_regs.sv ====
`timescale 1ns/100ps

module tb_xm_regs;

logic               clk = 1'b0;
logic               reset_i;
logic               bus_wr_i;
logic               bus_rd_i;
xm_pkg::reg_num_t   bus_reg_num_i;
logic               bus_bytesel_i;
xm_pkg::byte_t      bus_data_i;
xm_pkg::byte_t      bus_data_o;
logic               vram_sel_o;
logic               vram_wr_o;
xm_pkg::wrmask_t    vram_wrmask_o;
xm_pkg::addr_t      vram_addr_o;
xm_pkg::word_t      vram_data_o;
xm_pkg::word_t      vram_data_i = 16'h0000;
logic               vram_ack_i = 1'b0;
logic               h_blank_i;
logic               v_blank_i;
xm_pkg::intr_t      intr_mask_o;
xm_pkg::intr_t      intr_clear_o;
xm_pkg::intr_t      intr_status_i;

xm_pkg::word_t      vram_mem [0:255];       // VRAM model, addressed by low byte
xm_pkg::word_t      nib_mask;               // write mask spread over nibbles
integer             seed = 86177;
integer             fixed_delay = -1;       // -1 draws ack delay at random
integer             ack_cnt = 0;
logic               ack_wait = 1'b0;        // model holds an access
integer             limit_cycles = 0;       // watchdog length
integer             checks = 0;
integer             errors = 0;
logic [127:0]       op_q [$];               // case file columns
xm_pkg::word_t      reg_q [$];
xm_pkg::word_t      sel_q [$];
xm_pkg::word_t      dat_q [$];
xm_pkg::word_t      exp_q [$];

xm_regs_top u_xm_regs_top (.*);

bind xm_regs_top xm_regs_sva u_xm_regs_sva (.*);

always #2 clk = ~clk;                       // 4 ns period

assign nib_mask = {{4{vram_wrmask_o[3]}}, {4{vram_wrmask_o[2]}},
                   {4{vram_wrmask_o[1]}}, {4{vram_wrmask_o[0]}}};

// one access at a time, ack after a short count
always @(posedge clk) begin
    vram_ack_i <= 1'b0;
    if (vram_sel_o && !vram_ack_i && !ack_wait) begin
        ack_wait <= 1'b1;                   // new access seen
        if (fixed_delay < 0) begin
            ack_cnt <= $unsigned($random(seed)) % 6;
        end else begin
            ack_cnt <= fixed_delay;
        end
    end else if (ack_wait) begin
        if (ack_cnt == 0) begin
            ack_wait    <= 1'b0;
            vram_ack_i  <= 1'b1;
            vram_data_i <= vram_mem[vram_addr_o[7:0]];
            if (vram_wr_o) begin            // masked nibbles keep old value
                vram_mem[vram_addr_o[7:0]] <= (vram_mem[vram_addr_o[7:0]] & ~nib_mask)
                                            | (vram_data_o & nib_mask);
            end
        end else begin
            ack_cnt <= ack_cnt - 1;
        end
    end
end

task automatic check_value(input string name, input logic [15:0] got,
                           input logic [15:0] exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("MISMATCH %s got %h expected %h", name, got, exp);
    end
endtask

task automatic load_cases(output logic ok);
    integer         fd;
    integer         n;
    logic [127:0]   tok;
    logic [1023:0]  line_buf;
    xm_pkg::word_t  f_reg;
    xm_pkg::word_t  f_sel;
    xm_pkg::word_t  f_dat;
    xm_pkg::word_t  f_exp;
    ok = 1'b0;
    fd = $fopen("dv/xm_regs_cases.txt", "r");
    if (fd != 0) begin
        ok = 1'b1;
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok == "#") begin
                n = $fgets(line_buf, fd);   // skip comment line
            end else begin
                n = $fscanf(fd, "%h %h %h %h", f_reg, f_sel, f_dat, f_exp);
                if (n != 4) begin
                    ok = 1'b0;
                end
                op_q.push_back(tok);
                reg_q.push_back(f_reg);
                sel_q.push_back(f_sel);
                dat_q.push_back(f_dat);
                exp_q.push_back(f_exp);
            end
        end
        $fclose(fd);
    end
endtask

// write strobe, then intr_clear_o for two cycles
task automatic bus_write(input xm_pkg::reg_num_t rn, input logic sel,
                         input xm_pkg::byte_t d, input xm_pkg::intr_t clr);
    @(posedge clk);
    bus_wr_i      <= 1'b1;
    bus_reg_num_i <= rn;
    bus_bytesel_i <= sel;
    bus_data_i    <= d;
    @(posedge clk);
    bus_wr_i      <= 1'b0;
    @(negedge clk);
    check_value("intr_clear_o", {9'h000, intr_clear_o}, {9'h000, clr});
    if (rn == xm_pkg::XM_INT_CTRL && !sel) begin
        check_value("intr_mask_o", {9'h000, intr_mask_o}, {9'h000, d[6:0]});
    end
    @(negedge clk);
    check_value("intr_clear_o", {9'h000, intr_clear_o}, 16'h0000);
endtask

task automatic bus_read(input xm_pkg::reg_num_t rn, input logic sel,
                        output xm_pkg::byte_t got);
    @(posedge clk);
    bus_rd_i      <= 1'b1;
    bus_reg_num_i <= rn;
    bus_bytesel_i <= sel;
    @(negedge clk);
    got = bus_data_o;                       // mid cycle, inputs settled
    @(posedge clk);
    bus_rd_i      <= 1'b0;
endtask

task automatic wait_idle();
    xm_pkg::byte_t  st;
    integer         tries;
    st    = 8'h80;
    tries = 0;
    while (st[7] && tries < 200) begin      // bit 7 of SYS_CTRL high is mem_wait
        bus_read(xm_pkg::XM_SYS_CTRL, 1'b0, st);
        tries++;
    end
    if (st[7]) begin
        errors++;
        $display("mem_wait still set after %0d polls of SYS_CTRL", tries);
    end
endtask

task automatic timer_delta(input xm_pkg::word_t ticks, input xm_pkg::word_t exp_min);
    xm_pkg::byte_t  hi;
    xm_pkg::byte_t  lo;
    xm_pkg::word_t  t0;
    xm_pkg::word_t  delta;
    bus_read(xm_pkg::XM_TIMER, 1'b0, hi);   // high read latches low byte
    repeat (ticks * xm_pkg::CYCLES_PER_TICK) @(posedge clk);
    bus_read(xm_pkg::XM_TIMER, 1'b1, lo);   // still the byte latched with hi
    t0 = {hi, lo};
    bus_read(xm_pkg::XM_TIMER, 1'b0, hi);
    bus_read(xm_pkg::XM_TIMER, 1'b1, lo);
    delta = {hi, lo} - t0;
    // one extra tick can land inside the read window
    if (delta > exp_min) begin
        check_value("timer_delta", delta, exp_min + 16'd1);
    end else begin
        check_value("timer_delta", delta, exp_min);
    end
endtask

task automatic run_case(input integer idx);
    xm_pkg::byte_t got;
    if (op_q[idx] == "W") begin
        bus_write(reg_q[idx][3:0], sel_q[idx][0], dat_q[idx][7:0], exp_q[idx][6:0]);
    end else if (op_q[idx] == "R") begin
        bus_read(reg_q[idx][3:0], sel_q[idx][0], got);
        check_value("bus_data_o", {8'h00, got}, exp_q[idx]);
    end else if (op_q[idx] == "WAITIDLE") begin
        wait_idle();
    end else if (op_q[idx] == "M") begin
        @(negedge clk);
        check_value($sformatf("vram_mem[%02h]", dat_q[idx][7:0]),
                    vram_mem[dat_q[idx][7:0]], exp_q[idx]);
    end else if (op_q[idx] == "D") begin
        @(negedge clk);                     // away from the model's edge
        fixed_delay = (dat_q[idx] == 16'hffff) ? -1 : dat_q[idx];
    end else if (op_q[idx] == "TIMER") begin
        timer_delta(dat_q[idx], exp_q[idx]);
    end else begin
        errors++;
        $display("unknown operation %0s in case %0d", op_q[idx], idx);
    end
endtask

initial begin
    integer         a;
    integer         idx;
    integer         errs_before;
    logic           loaded;
    reset_i       = 1'b1;
    bus_wr_i      = 1'b0;
    bus_rd_i      = 1'b0;
    bus_reg_num_i = 4'h0;
    bus_bytesel_i = 1'b0;
    bus_data_i    = 8'h00;
    h_blank_i     = 1'b1;                   // shows in SYS_CTRL bit 11
    v_blank_i     = 1'b0;
    intr_status_i = 7'h12;
    for (a = 0; a < 256; a++) begin
        vram_mem[a] = {~a[7:0], a[7:0]};    // high byte tags the address
    end
    load_cases(loaded);
    if (!loaded) begin
        errors++;
        $display("case file dv/xm_regs_cases.txt missing or malformed");
    end else begin
        limit_cycles = op_q.size() * 200 + 12 * xm_pkg::CYCLES_PER_TICK;
        repeat (8) @(posedge clk);
        reset_i <= 1'b0;
        @(negedge clk);
        check_value("vram_sel_o", {15'h0000, vram_sel_o}, 16'h0000);
        for (idx = 0; idx < op_q.size(); idx++) begin
            errs_before = errors;
            run_case(idx);
            $display("case %0d %0s reg %h sel %0d data %h: %s", idx, op_q[idx],
                     reg_q[idx][3:0], sel_q[idx][0], dat_q[idx],
                     (errors == errs_before) ? "ok" : "failed");
        end
    end
    $display("%0d cases, %0d checks, %0d errors", op_q.size(), checks, errors);
    if (errors == 0) begin
        $display("TESTS PASSED");
    end else begin
        $display("TESTS FAILED");
    end
    $finish;
end

initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    $display("timeout after %0d cycles, the DUT stopped answering", limit_cycles);
    $display("TESTS FAILED");
    $finish;
end

endmodule

// ==== dv/xm_regs_sva.sv ====
`timescale 1ns/100ps

module xm_regs_sva (
    input  wire logic           clk,
    input  wire logic           reset_i,
    input  wire logic           vram_sel_o,
    input  wire logic           vram_wr_o,
    input  wire logic           vram_ack_i,
    input  wire xm_pkg::intr_t  intr_clear_o
);

// sel only drops after the ack cycle
sel_held_a: assert property (@(posedge clk) disable iff (reset_i)
    vram_sel_o && !vram_ack_i |=> vram_sel_o)
    else $error("vram_sel_o dropped before vram_ack_i");

// write strobe only inside a selected cycle
wr_in_sel_a: assert property (@(posedge clk) disable iff (reset_i)
    vram_wr_o |-> vram_sel_o)
    else $error("vram_wr_o high without vram_sel_o");

// clear strobe is one cycle wide
clear_pulse_a: assert property (@(posedge clk) disable iff (reset_i)
    intr_clear_o != '0 |=> intr_clear_o == '0)
    else $error("intr_clear_o held for more than one cycle");

endmodule

// ==== hdl/xm_regs_top.sv ====
`timescale 1ns/100ps

module xm_regs_top (
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire logic               bus_wr_i,           // one cycle write strobe
    input  wire logic               bus_rd_i,           // one cycle read strobe
    input  wire xm_pkg::reg_num_t   bus_reg_num_i,
    input  wire logic               bus_bytesel_i,
    input  wire xm_pkg::byte_t      bus_data_i,
    output      xm_pkg::byte_t      bus_data_o,
    output      logic               vram_sel_o,         // held until ack
    output      logic               vram_wr_o,
    output      xm_pkg::wrmask_t    vram_wrmask_o,
    output      xm_pkg::addr_t      vram_addr_o,
    output      xm_pkg::word_t      vram_data_o,
    input  wire xm_pkg::word_t      vram_data_i,
    input  wire logic               vram_ack_i,
    input  wire logic               h_blank_i,
    input  wire logic               v_blank_i,
    output      xm_pkg::intr_t      intr_mask_o,
    output      xm_pkg::intr_t      intr_clear_o,
    input  wire xm_pkg::intr_t      intr_status_i
);

xm_pkg::word_t  timer_word;                     // timer count to register file

vram_req_if u_vram_req ();

xm_reg_file u_xm_reg_file (
    .clk            (clk),
    .reset_i        (reset_i),
    .bus_wr_i       (bus_wr_i),
    .bus_rd_i       (bus_rd_i),
    .bus_reg_num_i  (bus_reg_num_i),
    .bus_bytesel_i  (bus_bytesel_i),
    .bus_data_i     (bus_data_i),
    .bus_data_o     (bus_data_o),
    .timer_i        (timer_word),
    .h_blank_i      (h_blank_i),
    .v_blank_i      (v_blank_i),
    .wrmask_o       (vram_wrmask_o),
    .intr_mask_o    (intr_mask_o),
    .intr_clear_o   (intr_clear_o),
    .intr_status_i  (intr_status_i),
    .req            (u_vram_req.regs)
);

vram_access_fsm u_vram_access_fsm (
    .clk            (clk),
    .reset_i        (reset_i),
    .vram_ack_i     (vram_ack_i),
    .vram_data_i    (vram_data_i),
    .vram_sel_o     (vram_sel_o),
    .vram_wr_o      (vram_wr_o),
    .vram_addr_o    (vram_addr_o),
    .vram_data_o    (vram_data_o),
    .req            (u_vram_req.seq)
);

tenth_ms_timer u_tenth_ms_timer (
    .clk            (clk),
    .reset_i        (reset_i),
    .timer_o        (timer_word)
);

endmodule

// ==== hdl/xm_reg_file.sv ====
`timescale 1ns/100ps

module xm_reg_file (
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire logic               bus_wr_i,           // byte write strobe
    input  wire logic               bus_rd_i,           // byte read strobe
    input  wire xm_pkg::reg_num_t   bus_reg_num_i,
    input  wire logic               bus_bytesel_i,      // 0 high byte, 1 low byte
    input  wire xm_pkg::byte_t      bus_data_i,
    output      xm_pkg::byte_t      bus_data_o,         // selected byte of read word
    input  wire xm_pkg::word_t      timer_i,            // free running 1/10 ms count
    input  wire logic               h_blank_i,
    input  wire logic               v_blank_i,
    output      xm_pkg::wrmask_t    wrmask_o,           // VRAM nibble mask
    output      xm_pkg::intr_t      intr_mask_o,
    output      xm_pkg::intr_t      intr_clear_o,       // one cycle clear strobe
    input  wire xm_pkg::intr_t      intr_status_i,
    vram_req_if.regs                req
);

xm_pkg::word_t      rd_incr_q;                  // RD_INCR
xm_pkg::addr_t      rd_addr_q;                  // RD_ADDR, next read-ahead address
xm_pkg::word_t      wr_incr_q;                  // WR_INCR
xm_pkg::addr_t      wr_addr_q;                  // WR_ADDR
xm_pkg::word_t      rd_data_q;                  // last word fetched from VRAM
xm_pkg::byte_t      data_even_q;                // high byte held for DATA write
xm_pkg::byte_t      timer_lo_q;                 // timer low byte, latched on high read
xm_pkg::intr_t      intr_mask_q;
logic               rd_incr_pend_q;             // RD_ADDR advance on next edge
logic               wr_incr_pend_q;             // WR_ADDR advance on next edge

logic               wr_lo;                      // low byte write this cycle
logic               wr_hi;                      // high byte write this cycle
logic               is_data;                    // DATA or DATA_2 addressed
logic               rd_addr_start;              // fetch from RD_ADDR write
logic               data_rd_start;              // read-ahead after DATA read
logic               incr_pend;
logic               mem_wait;
xm_pkg::word_t      rd_word;                    // word selected by read mux

assign wr_lo    = bus_wr_i & bus_bytesel_i;
assign wr_hi    = bus_wr_i & ~bus_bytesel_i;
assign is_data  = (bus_reg_num_i == xm_pkg::XM_DATA) || (bus_reg_num_i == xm_pkg::XM_DATA_2);

// requests go out in the strobe cycle so sel rises on the next edge
assign rd_addr_start = wr_lo & (bus_reg_num_i == xm_pkg::XM_RD_ADDR) & ~req.busy;
assign data_rd_start = bus_rd_i & bus_bytesel_i & is_data & ~req.busy;
assign req.rd_req    = rd_addr_start | data_rd_start;
assign req.wr_req    = wr_lo & is_data & ~req.busy;
assign req.wdata     = {data_even_q, bus_data_i};

always_comb begin
    if (rd_addr_start) begin
        req.addr = {rd_addr_q[15:8], bus_data_i};   // new address, not yet stored
    end else if (data_rd_start) begin
        req.addr = rd_addr_q;                       // already advanced by last read
    end else begin
        req.addr = wr_addr_q;
    end
end

// done counts as pending until the address has moved
assign incr_pend = req.done | rd_incr_pend_q | wr_incr_pend_q;
assign mem_wait  = req.busy | req.rd_req | req.wr_req | incr_pend;

assign intr_mask_o = intr_mask_q;

always_comb begin
    case (bus_reg_num_i)
        xm_pkg::XM_SYS_CTRL:
            rd_word = {mem_wait, 3'b000, h_blank_i, v_blank_i, 2'b00, 4'h0, wrmask_o};
        xm_pkg::XM_INT_CTRL:
            rd_word = {1'b0, intr_mask_q, 1'b0, intr_status_i};
        xm_pkg::XM_TIMER:
            rd_word = {timer_i[15:8], timer_lo_q};      // low byte from latch
        xm_pkg::XM_RD_INCR:
            rd_word = rd_incr_q;
        xm_pkg::XM_RD_ADDR:
            rd_word = rd_addr_q;
        xm_pkg::XM_WR_INCR:
            rd_word = wr_incr_q;
        xm_pkg::XM_WR_ADDR:
            rd_word = wr_addr_q;
        xm_pkg::XM_DATA, xm_pkg::XM_DATA_2:
            rd_word = rd_data_q;
        default:
            rd_word = 16'h0000;                         // dropped registers
    endcase
end

assign bus_data_o = bus_bytesel_i ? rd_word[7:0] : rd_word[15:8];

always_ff @(posedge clk) begin
    if (reset_i) begin
        rd_incr_q       <= 16'h0000;
        rd_addr_q       <= 16'h0000;
        wr_incr_q       <= 16'h0000;
        wr_addr_q       <= 16'h0000;
        wrmask_o        <= xm_pkg::WRMASK_RESET;
        intr_mask_q     <= '0;
        intr_clear_o    <= '0;
        rd_incr_pend_q  <= 1'b0;
        wr_incr_pend_q  <= 1'b0;
    end else begin
        intr_clear_o    <= '0;                          // strobe
        rd_incr_pend_q  <= req.done & req.done_rd;
        wr_incr_pend_q  <= req.done & ~req.done_rd;

        if (rd_incr_pend_q) begin
            rd_addr_q   <= rd_addr_q + rd_incr_q;
        end
        if (wr_incr_pend_q) begin
            wr_addr_q   <= wr_addr_q + wr_incr_q;
        end

        // host writes last, they win over an increment
        if (bus_wr_i) begin
            case (bus_reg_num_i)
                xm_pkg::XM_SYS_CTRL: if (wr_lo) wrmask_o <= bus_data_i[3:0];
                xm_pkg::XM_INT_CTRL: begin
                    if (wr_hi) begin
                        intr_mask_q     <= bus_data_i[6:0];
                    end else begin
                        intr_clear_o    <= bus_data_i[6:0];     // ack pending interrupts
                    end
                end
                xm_pkg::XM_RD_INCR: begin
                    if (wr_hi) rd_incr_q[15:8] <= bus_data_i;
                    else rd_incr_q[7:0] <= bus_data_i;
                end
                xm_pkg::XM_RD_ADDR: begin
                    if (wr_hi) rd_addr_q[15:8] <= bus_data_i;
                    else if (rd_addr_start) rd_addr_q[7:0] <= bus_data_i;
                end
                xm_pkg::XM_WR_INCR: begin
                    if (wr_hi) wr_incr_q[15:8] <= bus_data_i;
                    else wr_incr_q[7:0] <= bus_data_i;
                end
                xm_pkg::XM_WR_ADDR: begin
                    if (wr_hi) wr_addr_q[15:8] <= bus_data_i;
                    else wr_addr_q[7:0] <= bus_data_i;
                end
                default: begin
                end
            endcase
        end
    end
end

// data path registers
always_ff @(posedge clk) begin
    if (req.done && req.done_rd) begin
        rd_data_q   <= req.rdata;                       // read-ahead word
    end
    if (wr_hi && is_data) begin
        data_even_q <= bus_data_i;
    end
    if (bus_rd_i && !bus_bytesel_i && bus_reg_num_i == xm_pkg::XM_TIMER) begin
        timer_lo_q  <= timer_i[7:0];                    // keep word consistent
    end
end

endmodule

// ==== hdl/vram_access_fsm.sv ====
`timescale 1ns/100ps

module vram_access_fsm (
    input  wire logic           clk,
    input  wire logic           reset_i,
    input  wire logic           vram_ack_i,         // one cycle, any delay after sel
    input  wire xm_pkg::word_t  vram_data_i,        // valid in ack cycle
    output      logic           vram_sel_o,
    output      logic           vram_wr_o,
    output      xm_pkg::addr_t  vram_addr_o,
    output      xm_pkg::word_t  vram_data_o,
    vram_req_if.seq             req
);

xm_pkg::access_state_t  state_q;
logic                   done_q;                 // pulse after ack
logic                   done_rd_q;              // kind of access just ended
xm_pkg::word_t          rdata_q;                // word captured at ack

// sel and wr come straight off the state register
assign vram_sel_o   = (state_q != xm_pkg::ACC_IDLE);
assign vram_wr_o    = (state_q == xm_pkg::ACC_WRITE);

assign req.busy     = (state_q != xm_pkg::ACC_IDLE);
assign req.done     = done_q;
assign req.done_rd  = done_rd_q;
assign req.rdata    = rdata_q;

always_ff @(posedge clk) begin
    if (reset_i) begin
        state_q     <= xm_pkg::ACC_IDLE;
        done_q      <= 1'b0;
        done_rd_q   <= 1'b0;
    end else begin
        done_q      <= 1'b0;
        case (state_q)
            xm_pkg::ACC_IDLE: begin
                if (req.rd_req) begin
                    state_q     <= xm_pkg::ACC_READ;
                end else if (req.wr_req) begin
                    state_q     <= xm_pkg::ACC_WRITE;
                end
            end
            xm_pkg::ACC_READ, xm_pkg::ACC_WRITE: begin
                if (vram_ack_i) begin                   // late ack just holds sel
                    state_q     <= xm_pkg::ACC_IDLE;
                    done_q      <= 1'b1;
                    done_rd_q   <= (state_q == xm_pkg::ACC_READ);
                end
            end
            default: begin
                state_q     <= xm_pkg::ACC_IDLE;
            end
        endcase
    end
end

// address and data held for the whole access
always_ff @(posedge clk) begin
    if (state_q == xm_pkg::ACC_IDLE && (req.rd_req || req.wr_req)) begin
        vram_addr_o <= req.addr;
        vram_data_o <= req.wdata;
    end
    if (state_q == xm_pkg::ACC_READ && vram_ack_i) begin
        rdata_q     <= vram_data_i;
    end
end

endmodule

// ==== hdl/tenth_ms_timer.sv ====
`timescale 1ns/100ps

module tenth_ms_timer (
    input  wire logic           clk,
    input  wire logic           reset_i,
    output      xm_pkg::word_t  timer_o             // counts 1/10 ms, wraps
);

xm_pkg::frac_t  frac_q;                         // signed fraction accumulator
logic           tick;                           // one 1/10 ms period elapsed

// non-negative accumulator means a period has built up
assign tick = ~frac_q[xm_pkg::TIMER_FRAC_BITS-1];

always_ff @(posedge clk) begin
    if (reset_i) begin
        frac_q      <= '0;
        timer_o     <= 16'h0000;
    end else begin
        if (tick) begin
            frac_q  <= frac_q + xm_pkg::TIMER_FRAC_DEC; // step in, pay one period back
            timer_o <= timer_o + 16'h0001;
        end else begin
            frac_q  <= frac_q + xm_pkg::TIMER_FRAC_INC;
        end
    end
end

endmodule

// ==== hdl/vram_req_if.sv ====
`timescale 1ns/100ps

interface vram_req_if;

    logic           rd_req;                     // one cycle read request
    logic           wr_req;                     // one cycle write request
    xm_pkg::addr_t  addr;                       // word address of request
    xm_pkg::word_t  wdata;                      // write data of request
    logic           busy;                       // access in flight, no request allowed
    logic           done;                       // one cycle, access finished
    logic           done_rd;                    // finished access was a read
    xm_pkg::word_t  rdata;                      // read word, valid with done

    modport regs (                              // register file side
        output rd_req, wr_req, addr, wdata,
        input  busy, done, done_rd, rdata
    );

    modport seq (                               // access sequencer side
        input  rd_req, wr_req, addr, wdata,
        output busy, done, done_rd, rdata
    );

endinterface

// ==== hdl/xm_pkg.sv ====
package xm_pkg;

typedef logic [15:0] word_t;                    // register or VRAM data word
typedef logic [15:0] addr_t;                    // VRAM word address
typedef logic [7:0]  byte_t;                    // host bus byte
typedef logic [3:0]  reg_num_t;                 // host register number
typedef logic [3:0]  wrmask_t;                  // nibble write enables
typedef logic [6:0]  intr_t;                    // interrupt mask/clear/status

// host register numbers
localparam reg_num_t XM_SYS_CTRL  = 4'h0;       // mem_wait, blanking, write mask
localparam reg_num_t XM_INT_CTRL  = 4'h1;       // interrupt mask and clear
localparam reg_num_t XM_TIMER     = 4'h2;       // 1/10 ms timer
localparam reg_num_t XM_RD_XADDR  = 4'h3;       // reads zero
localparam reg_num_t XM_WR_XADDR  = 4'h4;       // reads zero
localparam reg_num_t XM_XDATA     = 4'h5;       // reads zero
localparam reg_num_t XM_RD_INCR   = 4'h6;
localparam reg_num_t XM_RD_ADDR   = 4'h7;       // low byte write starts a fetch
localparam reg_num_t XM_WR_INCR   = 4'h8;
localparam reg_num_t XM_WR_ADDR   = 4'h9;
localparam reg_num_t XM_DATA      = 4'hA;       // VRAM data port
localparam reg_num_t XM_DATA_2    = 4'hB;       // alias of DATA
localparam reg_num_t XM_PIXEL_X   = 4'hC;       // reads zero
localparam reg_num_t XM_PIXEL_Y   = 4'hD;       // reads zero
localparam reg_num_t XM_UART      = 4'hE;       // reads zero
localparam reg_num_t XM_FEATURE   = 4'hF;       // reads zero

// timer clock
localparam integer PCLK_HZ           = 25_000_000;
localparam integer TIMER_CLK_REDUCED = PCLK_HZ / 1000;     // reduced fraction of 10 kHz / pclk
localparam integer TIMER_HZ_REDUCED  = 10;
localparam integer TIMER_FRAC_BITS   = $clog2(TIMER_CLK_REDUCED) + 1;  // extra bit is the sign
localparam integer CYCLES_PER_TICK   = PCLK_HZ / 10_000;   // 2500 clocks per timer tick

typedef logic [TIMER_FRAC_BITS-1:0] frac_t;     // accumulator word

// accumulator steps, sized to the accumulator
localparam frac_t TIMER_FRAC_INC = TIMER_FRAC_BITS'(TIMER_HZ_REDUCED);
localparam frac_t TIMER_FRAC_DEC = TIMER_FRAC_BITS'(TIMER_HZ_REDUCED - TIMER_CLK_REDUCED);

localparam wrmask_t WRMASK_RESET = 4'b1111;     // all nibbles written

// VRAM access sequencer states
typedef enum logic [1:0] {
    ACC_IDLE,                                   // waiting for a request
    ACC_READ,                                   // read cycle, waiting for ack
    ACC_WRITE                                   // write cycle, waiting for ack
} access_state_t;

endpackage
